/* Bender.yml */
package:
  name: fm_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/fm_pkg.sv
      - design/fm_upd_if.sv
      - design/fm_cen_div.sv
      - design/fm_slot_seq.sv
      - design/fm_timers.sv
      - design/fm_mmr.sv
      - design/fm_param_store.sv
      - design/fm_top.sv
  - target: test
    files:
      - verification/fm_tb.sv

/* design/fm_cen_div.sv */
// slot clock-enable divider, one tick per 6, 3 or 2 clocks
// a new length only applies from the next wrap
`timescale 1ns/1ps
`default_nettype none

`include "fm_cfg.svh"

module fm_cen_div (
	input wire clk,
	input wire rst,
	input wire [1:0] div_sel,
	output logic tick
);

	logic [2:0] cnt;
	logic [2:0] sel_len;

	// 0 -> 6, 1 -> 3, 2 -> 2, 3 kept at 6
	always_comb begin
		case (div_sel)
			2'd1: sel_len = 3'd3;
			2'd2: sel_len = 3'd2;
			default: sel_len = 3'd6;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= 3'(`FM_DIV_RESET - 1);
			tick <= 1'b0;
		end else begin
			tick <= cnt == 3'd0;
			// length sampled here only, so a period is never cut short
			if (cnt == 3'd0)
				cnt <= sel_len - 3'd1;
			else
				cnt <= cnt - 3'd1;
		end
	end

endmodule

`default_nettype wire

/* design/fm_cfg.svh */
// sizes shared by the synthesizer control blocks
// slot indices are {ch, op}, so the slot count must stay 24
`ifndef FM_CFG_SVH
`define FM_CFG_SVH

// channel and operator layout
`define FM_NUM_CH 6
`define FM_NUM_OP 4
`define FM_NUM_SLOTS 24

// clock divider length after reset, in clocks per slot
`define FM_DIV_RESET 6

// sample strobes per timer B count
`define FM_TIMB_PRESCALE 16

`endif

/* design/fm_mmr.sv */
// host register decoder for the two-port address/data bus
// global registers 2xh are only decoded in bank 0; unknown registers are dropped
`timescale 1ns/1ps
`default_nettype none

module fm_mmr import fm_pkg::*; (
	input wire clk,
	input wire rst,
	input wire write,
	input wire [1:0] addr,
	input wire [7:0] din,
	fm_upd_if.src upd,
	output logic [1:0] div_sel,
	output logic [9:0] value_a,
	output logic [7:0] value_b,
	output logic load_a,
	output logic load_b,
	output logic en_a,
	output logic en_b,
	output logic clr_a,
	output logic clr_b
);

	logic [7:0] sel_reg;
	logic sel_bank;
	ch_idx_t sel_ch;
	op_idx_t sel_op;
	logic addr_wr;
	logic data_wr;
	logic glob_wr;
	logic upd_hit;
	upd_kind_e upd_kind_nxt;
	ch_idx_t upd_ch_nxt;
	ch_idx_t kon_ch;

	assign addr_wr = write && !addr[0];
	assign data_wr = write && addr[0];
	assign glob_wr = data_wr && !sel_bank && sel_reg[7:4] == 4'h2;
	// key on picks its own channel, din[2] is the bank
	assign kon_ch = (din[2] ? 3'd3 : 3'd0) + {1'b0, din[1:0]};

	// classify data writes that go to the parameter store
	always_comb begin
		upd_hit = 1'b0;
		upd_kind_nxt = UPD_TL;
		upd_ch_nxt = sel_ch;
		if (glob_wr && sel_reg == 8'h28) begin
			upd_hit = din[1:0] != 2'd3;
			upd_kind_nxt = UPD_KEYON;
			upd_ch_nxt = kon_ch;
		end else if (data_wr && sel_reg[1:0] != 2'd3) begin
			case (sel_reg[7:4])
				4'h3: begin
					upd_hit = 1'b1;
					upd_kind_nxt = UPD_DT_MUL;
				end
				4'h4: begin
					upd_hit = 1'b1;
					upd_kind_nxt = UPD_TL;
				end
				4'ha: begin
					upd_hit = sel_reg[3:2] == 2'd0 || sel_reg[3:2] == 2'd1;
					upd_kind_nxt = sel_reg[2] ? UPD_BLK_FHI : UPD_FNUM_LO;
				end
				4'hb: begin
					upd_hit = sel_reg[3:2] == 2'd0;
					upd_kind_nxt = UPD_FB_ALG;
				end
				default: upd_hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg <= '0;
			sel_bank <= 1'b0;
			sel_ch <= '0;
			sel_op <= '0;
			upd.valid <= 1'b0;
			div_sel <= 2'd0;
			value_a <= '0;
			value_b <= '0;
			{load_a, load_b, en_a, en_b} <= 4'b0;
			{clr_a, clr_b} <= 2'b0;
		end else begin
			upd.valid <= upd_hit;
			clr_a <= 1'b0;
			clr_b <= 1'b0;
			if (addr_wr) begin
				sel_reg <= din;
				sel_bank <= addr[1];
				sel_ch <= (addr[1] ? 3'd3 : 3'd0) + {1'b0, din[1:0]};
				// 0=S1 1=S3 2=S2 3=S4, swapped into S1..S4 numbering
				sel_op <= {din[2], din[3]};
			end
			if (glob_wr) begin
				case (sel_reg)
					8'h24: value_a[9:2] <= din;
					8'h25: value_a[1:0] <= din[1:0];
					8'h26: value_b <= din;
					8'h27: begin
						{en_b, en_a, load_b, load_a} <= din[3:0];
						{clr_b, clr_a} <= din[5:4];
					end
					8'h2d: div_sel <= 2'd0;
					8'h2e: div_sel <= 2'd1;
					8'h2f: div_sel <= 2'd2;
					default: ;
				endcase
			end
		end
	end

	// update payload, qualified by valid
	always_ff @(posedge clk) begin
		if (upd_hit) begin
			upd.kind <= upd_kind_nxt;
			upd.ch <= upd_ch_nxt;
			upd.op <= sel_op;
			upd.data <= din;
		end
	end

endmodule

`default_nettype wire

/* design/fm_param_store.sv */
// channel and operator parameter arrays with a single pending update
// a newer update replaces one that has not yet reached its slot
`timescale 1ns/1ps
`default_nettype none

`include "fm_cfg.svh"

module fm_param_store import fm_pkg::*; (
	input wire clk,
	input wire rst,
	fm_upd_if.dst upd,
	input wire ch_idx_t cur_ch,
	input wire op_idx_t cur_op,
	output logic [10:0] fnum,
	output logic [2:0] block,
	output logic [2:0] fb,
	output logic [2:0] alg,
	output logic [2:0] dt,
	output logic [3:0] mul,
	output logic [6:0] tl,
	output logic keyon
);

	// per channel
	logic [7:0] fnum_lo_mem [`FM_NUM_CH];
	logic [2:0] fhi_mem [`FM_NUM_CH];
	logic [2:0] block_mem [`FM_NUM_CH];
	logic [2:0] fb_mem [`FM_NUM_CH];
	logic [2:0] alg_mem [`FM_NUM_CH];
	// per slot, indexed {ch, op}
	logic [2:0] dt_mem [`FM_NUM_SLOTS];
	logic [3:0] mul_mem [`FM_NUM_SLOTS];
	logic [6:0] tl_mem [`FM_NUM_SLOTS];
	logic [`FM_NUM_SLOTS-1:0] keyon_mem;

	upd_kind_e pend_kind;
	ch_idx_t pend_ch;
	op_idx_t pend_op;
	param_byte_u pend_data;
	logic take;
	logic is_ch_kind;
	op_idx_t tgt_op;
	logic commit;
	logic [4:0] pend_slot;
	logic [4:0] cur_slot;

	assign take = upd.valid && upd.kind != UPD_KEYON;
	assign is_ch_kind = pend_kind inside {UPD_FNUM_LO, UPD_BLK_FHI, UPD_FB_ALG};
	// channel data lands when S1 of that channel comes round
	assign tgt_op = is_ch_kind ? 2'd0 : pend_op;
	assign commit = upd.pending && cur_ch == pend_ch && cur_op == tgt_op;
	assign pend_slot = {pend_ch, pend_op};
	assign cur_slot = {cur_ch, cur_op};

	always_ff @(posedge clk) begin
		if (rst)
			upd.pending <= 1'b0;
		else if (take)
			upd.pending <= 1'b1;
		else if (commit)
			upd.pending <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			pend_kind <= upd.kind;
			pend_ch <= upd.ch;
			pend_op <= upd.op;
			pend_data <= upd.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_NUM_CH; i++) begin
				fnum_lo_mem[i] <= '0;
				fhi_mem[i] <= '0;
				block_mem[i] <= '0;
				fb_mem[i] <= '0;
				alg_mem[i] <= '0;
			end
			for (int s = 0; s < `FM_NUM_SLOTS; s++) begin
				dt_mem[s] <= '0;
				mul_mem[s] <= '0;
				tl_mem[s] <= '0;
			end
			keyon_mem <= '0;
		end else begin
			// key on goes straight in, mask bit 4 is S1
			if (upd.valid && upd.kind == UPD_KEYON) begin
				for (int i = 0; i < `FM_NUM_OP; i++)
					keyon_mem[{upd.ch, 2'(i)}] <= upd.data[4 + i];
			end
			if (commit) begin
				case (pend_kind)
					UPD_FNUM_LO: fnum_lo_mem[pend_ch] <= pend_data.fnum_lo;
					UPD_BLK_FHI: begin
						block_mem[pend_ch] <= pend_data.blk_fhi.block;
						fhi_mem[pend_ch] <= pend_data.blk_fhi.fhi;
					end
					UPD_FB_ALG: begin
						fb_mem[pend_ch] <= pend_data.fb_alg.fb;
						alg_mem[pend_ch] <= pend_data.fb_alg.alg;
					end
					UPD_DT_MUL: begin
						dt_mem[pend_slot] <= pend_data.dt_mul.dt;
						mul_mem[pend_slot] <= pend_data.dt_mul.mul;
					end
					UPD_TL: tl_mem[pend_slot] <= pend_data.tl.tl;
					default: ;
				endcase
			end
		end
	end

	// readout of the slot now on show
	assign fnum = {fhi_mem[cur_ch], fnum_lo_mem[cur_ch]};
	assign block = block_mem[cur_ch];
	assign fb = fb_mem[cur_ch];
	assign alg = alg_mem[cur_ch];
	assign dt = dt_mem[cur_slot];
	assign mul = mul_mem[cur_slot];
	assign tl = tl_mem[cur_slot];
	assign keyon = keyon_mem[cur_slot];

endmodule

`default_nettype wire

/* design/fm_pkg.sv */
// types shared by the register decoder, parameter store and slot sequencer
// op_idx_t uses S1, S2, S3, S4 numbering, not hardware order
`default_nettype none

package fm_pkg;

	typedef enum logic [2:0] {
		UPD_FNUM_LO,
		UPD_BLK_FHI,
		UPD_FB_ALG,
		UPD_DT_MUL,
		UPD_TL,
		UPD_KEYON
	} upd_kind_e;

	typedef logic [2:0] ch_idx_t;
	typedef logic [1:0] op_idx_t;

	// hardware visit order of the operators
	typedef enum logic [1:0] {
		PH_S1,
		PH_S3,
		PH_S2,
		PH_S4
	} op_phase_e;

	// one data byte, decoded by register kind
	typedef union packed {
		logic [7:0] fnum_lo;
		struct packed {logic [1:0] unused; logic [2:0] block; logic [2:0] fhi;} blk_fhi;
		struct packed {logic [1:0] unused; logic [2:0] fb; logic [2:0] alg;} fb_alg;
		struct packed {logic unused; logic [2:0] dt; logic [3:0] mul;} dt_mul;
		struct packed {logic unused; logic [6:0] tl;} tl;
	} param_byte_u;

endpackage

`default_nettype wire

/* design/fm_slot_seq.sv */
// steps 6 channels per phase through phases S1, S3, S2, S4
// slot changes on the clock after tick, together with slot_tick
`timescale 1ns/1ps
`default_nettype none

`include "fm_cfg.svh"

module fm_slot_seq import fm_pkg::*; (
	input wire clk,
	input wire rst,
	input wire tick,
	output ch_idx_t cur_ch,
	output op_idx_t cur_op,
	output logic slot_tick,
	output logic sample
);

	op_phase_e phase;
	op_phase_e next_phase;
	logic last_ch;

	assign last_ch = cur_ch == 3'(`FM_NUM_CH - 1);

	always_comb begin
		case (phase)
			PH_S1: begin
				next_phase = PH_S3;
				cur_op = 2'd0;
			end
			PH_S3: begin
				next_phase = PH_S2;
				cur_op = 2'd2;
			end
			PH_S2: begin
				next_phase = PH_S4;
				cur_op = 2'd1;
			end
			default: begin
				next_phase = PH_S1;
				cur_op = 2'd3;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= PH_S1;
			cur_ch <= '0;
			slot_tick <= 1'b0;
			sample <= 1'b0;
		end else begin
			slot_tick <= tick;
			// end of slot 24, wrapping to ch 0 S1
			sample <= tick && last_ch && phase == PH_S4;
			if (tick) begin
				if (last_ch) begin
					cur_ch <= '0;
					phase <= next_phase;
				end else begin
					cur_ch <= cur_ch + 3'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* design/fm_timers.sv */
// timer A (10 bit) and timer B (8 bit, prescaled) counting sample strobes
// a counter reloads on its load rising edge and holds while load is low
`timescale 1ns/1ps
`default_nettype none

`include "fm_cfg.svh"

module fm_timers (
	input wire clk,
	input wire rst,
	input wire sample,
	input wire [9:0] value_a,
	input wire [7:0] value_b,
	input wire load_a,
	input wire load_b,
	input wire en_a,
	input wire en_b,
	input wire clr_a,
	input wire clr_b,
	output logic flag_a,
	output logic flag_b,
	output logic irq
);

	logic [9:0] cnt_a;
	logic [7:0] cnt_b;
	logic [3:0] pre_b;
	logic load_a_q;
	logic load_b_q;
	logic step_a;
	logic step_b;
	logic ovf_a;
	logic ovf_b;

	assign step_a = sample && load_a && load_a_q;
	// timer B only counts once per prescaler wrap
	assign step_b = sample && load_b && load_b_q && pre_b == 4'(`FM_TIMB_PRESCALE - 1);
	assign ovf_a = step_a && cnt_a == 10'h3ff;
	assign ovf_b = step_b && cnt_b == 8'hff;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt_a <= '0;
			cnt_b <= '0;
			pre_b <= '0;
			load_a_q <= 1'b0;
			load_b_q <= 1'b0;
			flag_a <= 1'b0;
			flag_b <= 1'b0;
			irq <= 1'b0;
		end else begin
			load_a_q <= load_a;
			load_b_q <= load_b;
			irq <= flag_a | flag_b;

			if (load_a && !load_a_q)
				cnt_a <= value_a;
			else if (step_a)
				cnt_a <= ovf_a ? value_a : cnt_a + 10'd1;

			if (load_b && !load_b_q) begin
				cnt_b <= value_b;
				pre_b <= '0;
			end else if (sample && load_b) begin
				pre_b <= pre_b + 4'd1;
				if (step_b)
					cnt_b <= ovf_b ? value_b : cnt_b + 8'd1;
			end

			// clear wins over a same-cycle overflow
			if (clr_a)
				flag_a <= 1'b0;
			else if (ovf_a && en_a)
				flag_a <= 1'b1;
			if (clr_b)
				flag_b <= 1'b0;
			else if (ovf_b && en_b)
				flag_b <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/fm_top.sv */
// FM control subsystem: host registers, slot sequencer, parameter store, timers
// host must wait for busy low before the next parameter data write
`timescale 1ns/1ps
`default_nettype none

module fm_top import fm_pkg::*; (
	input wire clk,
	input wire rst,
	input wire write,
	input wire [1:0] addr,
	input wire [7:0] din,
	output logic busy,
	output logic irq,
	output logic flag_a,
	output logic flag_b,
	output logic slot_tick,
	output logic [2:0] slot_ch,
	output logic [1:0] slot_op,
	output logic [10:0] slot_fnum,
	output logic [2:0] slot_block,
	output logic [2:0] slot_fb,
	output logic [2:0] slot_alg,
	output logic [2:0] slot_dt,
	output logic [3:0] slot_mul,
	output logic [6:0] slot_tl,
	output logic slot_keyon
);

	fm_upd_if upd_bus ();

	logic tick;
	logic sample;
	ch_idx_t cur_ch;
	op_idx_t cur_op;
	logic [1:0] div_sel;
	logic [9:0] value_a;
	logic [7:0] value_b;
	logic load_a;
	logic load_b;
	logic en_a;
	logic en_b;
	logic clr_a;
	logic clr_b;

	assign busy = upd_bus.pending;
	assign slot_ch = cur_ch;
	assign slot_op = cur_op;

	fm_cen_div u_div (
		.clk(clk), .rst(rst), .div_sel(div_sel), .tick(tick)
	);

	fm_slot_seq u_seq (
		.clk(clk), .rst(rst), .tick(tick),
		.cur_ch(cur_ch), .cur_op(cur_op), .slot_tick(slot_tick), .sample(sample)
	);

	fm_mmr u_mmr (
		.clk(clk), .rst(rst), .write(write), .addr(addr), .din(din),
		.upd(upd_bus.src), .div_sel(div_sel),
		.value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
		.en_a(en_a), .en_b(en_b), .clr_a(clr_a), .clr_b(clr_b)
	);

	fm_param_store u_store (
		.clk(clk), .rst(rst), .upd(upd_bus.dst), .cur_ch(cur_ch), .cur_op(cur_op),
		.fnum(slot_fnum), .block(slot_block), .fb(slot_fb), .alg(slot_alg),
		.dt(slot_dt), .mul(slot_mul), .tl(slot_tl), .keyon(slot_keyon)
	);

	fm_timers u_timers (
		.clk(clk), .rst(rst), .sample(sample),
		.value_a(value_a), .value_b(value_b), .load_a(load_a), .load_b(load_b),
		.en_a(en_a), .en_b(en_b), .clr_a(clr_a), .clr_b(clr_b),
		.flag_a(flag_a), .flag_b(flag_b), .irq(irq)
	);

endmodule

`default_nettype wire

/* design/fm_upd_if.sv */
// one parameter update from the register decoder to the parameter store
// valid is a single-cycle strobe; pending holds until the update lands
`timescale 1ns/1ps
`default_nettype none

interface fm_upd_if import fm_pkg::*; ();

	logic valid;
	upd_kind_e kind;
	ch_idx_t ch;
	// for key on this is unused
	op_idx_t op;
	// key on carries the operator mask in data[7:4]
	param_byte_u data;
	logic pending;

	modport src (
		output valid, kind, ch, op, data,
		input pending
	);

	modport dst (
		input valid, kind, ch, op, data,
		output pending
	);

endinterface

`default_nettype wire

/* files.f */
+incdir+design
design/fm_pkg.sv
design/fm_upd_if.sv
design/fm_cen_div.sv
design/fm_slot_seq.sv
design/fm_timers.sv
design/fm_mmr.sv
design/fm_param_store.sv
design/fm_top.sv
verification/fm_tb.sv

/* verification/fm_tb.sv */
// self-checking testbench for fm_top with slot values checked on every slot_tick
// global registers are written through bank 0 only
`timescale 1ns/1ps
`default_nettype none

module fm_tb;

	localparam logic [31:0] SEED = 32'h186b57bc;
	// one full slot sequence at the slowest divider
	localparam int SEQ_CLKS = 24 * 6;
	localparam int WRITE_CLKS = 200 * (2 * SEQ_CLKS + 8);
	localparam int TIMER_CLKS = 2 * 1024 * SEQ_CLKS;
	localparam int MAX_CYCLES = 3 * (TIMER_CLKS + WRITE_CLKS) / 2;
	localparam int BUSY_LIMIT = 4 * SEQ_CLKS;

	logic clk;
	logic rst;
	logic write;
	logic [1:0] addr;
	logic [7:0] din;
	logic busy;
	logic irq;
	logic flag_a;
	logic flag_b;
	logic slot_tick;
	logic [2:0] slot_ch;
	logic [1:0] slot_op;
	logic [10:0] slot_fnum;
	logic [2:0] slot_block;
	logic [2:0] slot_fb;
	logic [2:0] slot_alg;
	logic [2:0] slot_dt;
	logic [3:0] slot_mul;
	logic [6:0] slot_tl;
	logic slot_keyon;

	// reference model
	logic [7:0] m_fnum_lo [6];
	logic [2:0] m_fhi [6];
	logic [2:0] m_block [6];
	logic [2:0] m_fb [6];
	logic [2:0] m_alg [6];
	logic [2:0] m_dt [24];
	logic [3:0] m_mul [24];
	logic [6:0] m_tl [24];
	logic m_keyon [24];

	string test_name = "init";
	int cycles = 0;
	int seq_pos;
	int unsigned seed_dummy;
	logic [2:0] exp_ch;
	logic [1:0] exp_op;
	logic [4:0] slot_idx;

	fm_top DUT (
		.clk(clk), .rst(rst), .write(write), .addr(addr), .din(din),
		.busy(busy), .irq(irq), .flag_a(flag_a), .flag_b(flag_b),
		.slot_tick(slot_tick), .slot_ch(slot_ch), .slot_op(slot_op),
		.slot_fnum(slot_fnum), .slot_block(slot_block), .slot_fb(slot_fb),
		.slot_alg(slot_alg), .slot_dt(slot_dt), .slot_mul(slot_mul),
		.slot_tl(slot_tl), .slot_keyon(slot_keyon)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// S2 and S3 trade places, both in visit order and in the address field
	function automatic logic [1:0] order_map(input int v);
		case (v)
			0: return 2'd0;
			1: return 2'd2;
			2: return 2'd1;
			default: return 2'd3;
		endcase
	endfunction

	task automatic finish_failed();
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string field, input int unsigned exp_v,
			input int unsigned act_v);
		$display("** Error [%s] %s: expected 0x%0h, actual 0x%0h", test_name, field,
			exp_v, act_v);
		finish_failed();
	endtask

	task automatic plain_failure(input string why);
		$display("[%s] %s", test_name, why);
		finish_failed();
	endtask

	// slot currently on show, advanced mid-cycle after each slot_tick
	always @(negedge clk) begin
		if (rst)
			seq_pos <= 0;
		else if (slot_tick)
			seq_pos <= (seq_pos == 23) ? 0 : seq_pos + 1;
	end

	assign exp_ch = 3'(seq_pos % 6);
	assign exp_op = order_map(seq_pos / 6);
	assign slot_idx = 5'(exp_ch * 4 + exp_op);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES)
			plain_failure("run timed out");
	end

	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_ch == exp_ch)
		else value_mismatch("slot_ch", $sampled(exp_ch), $sampled(slot_ch));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_op == exp_op)
		else value_mismatch("slot_op", $sampled(exp_op), $sampled(slot_op));
	assert property (@(posedge clk) disable iff (rst)
		slot_tick |-> slot_fnum == {m_fhi[exp_ch], m_fnum_lo[exp_ch]})
		else value_mismatch("slot_fnum", $sampled({m_fhi[exp_ch], m_fnum_lo[exp_ch]}),
			$sampled(slot_fnum));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_block == m_block[exp_ch])
		else value_mismatch("slot_block", $sampled(m_block[exp_ch]), $sampled(slot_block));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_fb == m_fb[exp_ch])
		else value_mismatch("slot_fb", $sampled(m_fb[exp_ch]), $sampled(slot_fb));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_alg == m_alg[exp_ch])
		else value_mismatch("slot_alg", $sampled(m_alg[exp_ch]), $sampled(slot_alg));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_dt == m_dt[slot_idx])
		else value_mismatch("slot_dt", $sampled(m_dt[slot_idx]), $sampled(slot_dt));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_mul == m_mul[slot_idx])
		else value_mismatch("slot_mul", $sampled(m_mul[slot_idx]), $sampled(slot_mul));
	assert property (@(posedge clk) disable iff (rst) slot_tick |-> slot_tl == m_tl[slot_idx])
		else value_mismatch("slot_tl", $sampled(m_tl[slot_idx]), $sampled(slot_tl));
	assert property (@(posedge clk) disable iff (rst)
		slot_tick |-> slot_keyon == m_keyon[slot_idx])
		else value_mismatch("slot_keyon", $sampled(m_keyon[slot_idx]), $sampled(slot_keyon));
	// timer B is never enabled
	assert property (@(posedge clk) disable iff (rst) !flag_b)
		else value_mismatch("flag_b", 0, 1);

	// address write then data write, entered 2 ns after an edge
	task automatic write_reg(input logic bank, input logic [7:0] reg_addr,
			input logic [7:0] data);
		write = 1'b1;
		addr = {bank, 1'b0};
		din = reg_addr;
		@(posedge clk);
		#2;
		addr = {bank, 1'b1};
		din = data;
		@(posedge clk);
		#2;
		write = 1'b0;
	endtask

	task automatic wait_busy();
		int n;
		n = 0;
		@(posedge clk);
		#2;
		assert (busy) else plain_failure("busy did not rise after a parameter write");
		while (busy) begin
			@(posedge clk);
			#2;
			n++;
			if (n > BUSY_LIMIT)
				plain_failure("busy stuck high");
		end
	endtask

	task automatic wait_ticks(input int n);
		int seen;
		int cyc;
		seen = 0;
		cyc = 0;
		while (seen < n) begin
			@(posedge clk);
			#2;
			cyc++;
			if (slot_tick)
				seen++;
			if (cyc > 8 * n + 16)
				plain_failure("slot_tick stopped");
		end
	endtask

	task automatic measure_spacing(input int expected);
		int gap;
		// old period may still be running
		wait_ticks(2);
		repeat (3) begin
			gap = 0;
			do begin
				@(posedge clk);
				#2;
				gap++;
			end while (!slot_tick && gap < 16);
			assert (gap == expected) else value_mismatch("tick spacing", expected, gap);
		end
	endtask

	task automatic verify_reset();
		test_name = "reset";
		assert (!busy && !irq && !flag_a && !flag_b)
			else plain_failure("status outputs not low after reset");
		wait_ticks(25);
	endtask

	task automatic channel_writes();
		int ch;
		int lo;
		logic [7:0] d;
		test_name = "channel";
		for (int i = 0; i < 6; i++) begin
			// alternate banks
			ch = (i % 2 == 1) ? 3 + $urandom % 3 : $urandom % 3;
			lo = ch % 3;
			d = 8'($urandom);
			write_reg(ch >= 3, 8'(8'ha4 + lo), d);
			wait_busy();
			m_block[ch] = d[5:3];
			m_fhi[ch] = d[2:0];
			d = 8'($urandom);
			write_reg(ch >= 3, 8'(8'ha0 + lo), d);
			wait_busy();
			m_fnum_lo[ch] = d;
			d = 8'($urandom);
			write_reg(ch >= 3, 8'(8'hb0 + lo), d);
			wait_busy();
			m_fb[ch] = d[5:3];
			m_alg[ch] = d[2:0];
			wait_ticks(24);
		end
	endtask

	task automatic operator_writes();
		int ch;
		int op;
		int s;
		logic [7:0] base;
		logic [7:0] d;
		test_name = "operator";
		for (int i = 0; i < 8; i++) begin
			ch = $urandom % 6;
			op = $urandom % 4;
			s = ch * 4 + op;
			base = 8'(4 * order_map(op) + ch % 3);
			d = 8'($urandom);
			write_reg(ch >= 3, 8'(8'h30 + base), d);
			wait_busy();
			m_dt[s] = d[6:4];
			m_mul[s] = d[3:0];
			d = 8'($urandom);
			write_reg(ch >= 3, 8'(8'h40 + base), d);
			wait_busy();
			m_tl[s] = d[6:0];
			wait_ticks(24);
		end
	endtask

	task automatic keyon_mask();
		int ch;
		int keyed [2];
		logic [3:0] mask;
		test_name = "keyon";
		for (int i = 0; i < 4; i++) begin
			// one channel per bank keyed on, then both cleared again
			if (i < 2) begin
				ch = 3 * i + $urandom % 3;
				keyed[i] = ch;
			end else begin
				ch = keyed[i - 2];
			end
			mask = (i < 2) ? 4'(1 + $urandom % 15) : 4'd0;
			write_reg(1'b0, 8'h28, {mask, 1'b0, ch >= 3, 2'(ch % 3)});
			// lands one cycle after the strobe, without busy
			@(posedge clk);
			#2;
			for (int op = 0; op < 4; op++)
				m_keyon[ch * 4 + op] = mask[op];
			assert (!busy) else plain_failure("key on raised busy");
			@(posedge clk);
			#2;
			assert (!busy) else plain_failure("key on raised busy");
			wait_ticks(24);
		end
	endtask

	task automatic divider_spacing();
		test_name = "divider";
		write_reg(1'b0, 8'h2e, 8'h00);
		measure_spacing(3);
		write_reg(1'b0, 8'h2f, 8'h00);
		measure_spacing(2);
		write_reg(1'b0, 8'h2d, 8'h00);
		measure_spacing(6);
	endtask

	task automatic timer_flags();
		int cyc;
		test_name = "timers";
		write_reg(1'b0, 8'h2f, 8'h00);
		// timer A at 1020, timer B near overflow
		write_reg(1'b0, 8'h24, 8'hff);
		write_reg(1'b0, 8'h25, 8'h00);
		write_reg(1'b0, 8'h26, 8'hfe);
		// load A and B, enable A only
		write_reg(1'b0, 8'h27, 8'h07);
		cyc = 0;
		while (!flag_a) begin
			@(posedge clk);
			#2;
			cyc++;
			if (cyc > 8 * SEQ_CLKS)
				plain_failure("flag_a did not rise");
		end
		@(posedge clk);
		#2;
		assert (irq) else value_mismatch("irq", 1, irq);
		write_reg(1'b0, 8'h27, 8'h17);
		@(posedge clk);
		#2;
		assert (!flag_a) else value_mismatch("flag_a after clear", 0, flag_a);
		@(posedge clk);
		#2;
		assert (!irq) else value_mismatch("irq after clear", 0, irq);
		// long enough for timer B to wrap if it were enabled
		wait_ticks(24 * 40);
	endtask

	initial begin
		seed_dummy = $urandom(SEED);
		rst = 1'b1;
		write = 1'b0;
		addr = 2'd0;
		din = 8'd0;
		for (int c = 0; c < 6; c++) begin
			m_fnum_lo[c] = '0;
			m_fhi[c] = '0;
			m_block[c] = '0;
			m_fb[c] = '0;
			m_alg[c] = '0;
		end
		for (int s = 0; s < 24; s++) begin
			m_dt[s] = '0;
			m_mul[s] = '0;
			m_tl[s] = '0;
			m_keyon[s] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		verify_reset();
		channel_writes();
		operator_writes();
		keyon_mask();
		divider_spacing();
		timer_flags();
		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire
